// File: sd_debug_cfg.svh
// Depth, break point count and register map of the debug trace unit; include where needed
`ifndef SD_DEBUG_CFG_SVH
`define SD_DEBUG_CFG_SVH

// ========================================
// Buffer sizes
// ========================================
`define SD_DBG_TRACE_DEPTH 16      // Trace records
`define SD_DBG_PERF_DEPTH  8       // Performance samples
`define SD_DBG_NUM_BREAK   8       // Break point comparators

// ========================================
// APB register map, byte offsets
// ========================================
`define SD_DBG_ADDR_W          8
`define SD_DBG_REG_CTRL        8'h00
`define SD_DBG_REG_STATUS      8'h04
`define SD_DBG_REG_TRACE_DATA  8'h08   // Read pops the trace head
`define SD_DBG_REG_TRACE_TYPE  8'h0C
`define SD_DBG_REG_BREAK_EN    8'h10
`define SD_DBG_REG_PERF_DATA   8'h14   // Read pops the perf head

// First break value, the rest follow at 4-byte steps
`define SD_DBG_REG_BREAK_VAL   8'h20

`endif

// File: sd_debug_bus_pkg.sv
// APB request and response types of the debug unit, imported by RTL and testbench
`default_nettype none

`include "sd_debug_cfg.svh"

package sd_debug_bus_pkg;

    // Byte offset into the register map
    typedef logic [`SD_DBG_ADDR_W-1:0] reg_addr_t;

    // Master to slave
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        reg_addr_t   paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    // Slave to master
    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;     // Tied high, no wait states
        logic        pslverr;
    } apb_rsp_t;

endpackage

`default_nettype wire

// File: sd_debug_trace_pkg.sv
// Trace, performance and control types of the capture path, imported by the datapath modules
`default_nettype none

`include "sd_debug_cfg.svh"

package sd_debug_trace_pkg;

    // One record from the SD controller
    typedef struct packed {
        logic [3:0]  rec_type;
        logic [31:0] data;
    } trace_rec_t;

    // Raw performance counter value
    typedef logic [15:0] perf_sample_t;

    // Break point compare against the low half of the trace word
    typedef struct packed {
        logic [`SD_DBG_NUM_BREAK-1:0]       en;
        logic [`SD_DBG_NUM_BREAK-1:0][15:0] val;
    } break_cfg_t;

    // CTRL bits 2:0
    typedef struct packed {
        logic perf_en;    // Bit 2
        logic trace_en;   // Bit 1
        logic debug_en;   // Bit 0, master enable
    } dbg_ctrl_t;

endpackage

`default_nettype wire

// File: sd_debug_fifo.sv
// Show-ahead circular buffer for any payload type, used for the trace and perf streams
`default_nettype none

module sd_debug_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 16
) (
    input  wire                           PCLK_i,
    input  wire                           PRESETn_i,
    input  wire                           clear_i,
    input  wire                           push_i,
    input  wire                           pop_i,
    input  wire payload_t                 wdata_i,
    output payload_t                      rdata_o,    // Head entry, valid when not empty
    output logic [$clog2(DEPTH+1)-1:0]    level_o,
    output logic                          full_o,
    output logic                          empty_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int LVL_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [LVL_W-1:0] level;
    logic             do_push;
    logic             do_pop;

    // Wrap also for depths that are not a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full_o  = (level == LVL_W'(DEPTH));
    assign empty_o = (level == '0);
    assign do_push = push_i & ~full_o;   // Push on full dropped
    assign do_pop  = pop_i & ~empty_o;   // Pop on empty dropped
    assign rdata_o = mem[rd_ptr];
    assign level_o = level;

    always_ff @(posedge PCLK_i or negedge PRESETn_i) begin
        if (!PRESETn_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else if (clear_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (do_push) wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)  rd_ptr <= next_ptr(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    // Storage array
    always_ff @(posedge PCLK_i) begin
        if (do_push) begin
            mem[wr_ptr] <= wdata_i;
        end
    end

endmodule

`default_nettype wire

// File: sd_debug_trace_gate.sv
// Trace acceptance and break point match, keeps the sticky hit and overflow flags
`default_nettype none

`include "sd_debug_cfg.svh"

module sd_debug_trace_gate
    import sd_debug_trace_pkg::*;
(
    input  wire              PCLK_i,
    input  wire              PRESETn_i,
    input  wire dbg_ctrl_t   ctrl_i,
    input  wire break_cfg_t  break_cfg_i,
    input  wire              clear_i,
    input  wire              trace_valid_i,
    input  wire trace_rec_t  trace_rec_i,
    input  wire              fifo_full_i,
    output logic             trace_ready_o,
    output logic             push_o,
    output logic             break_hit_o,
    output logic             overflow_o
);

    logic capture_on;
    logic bp_match;
    logic overrun;

    assign capture_on    = ctrl_i.debug_en & ctrl_i.trace_en & ~break_hit_o;
    assign trace_ready_o = capture_on & ~fifo_full_i;
    assign push_o        = trace_valid_i & trace_ready_o;
    assign overrun       = trace_valid_i & capture_on & fifo_full_i;   // Record offered, no room

    // All comparators in parallel
    always_comb begin
        bp_match = 1'b0;
        for (int i = 0; i < `SD_DBG_NUM_BREAK; i++) begin
            if (break_cfg_i.en[i] && (trace_rec_i.data[15:0] == break_cfg_i.val[i])) begin
                bp_match = 1'b1;
            end
        end
    end

    // ========================================
    // Sticky flags, dropped only by a clear
    // ========================================
    always_ff @(posedge PCLK_i or negedge PRESETn_i) begin
        if (!PRESETn_i) begin
            break_hit_o <= 1'b0;
            overflow_o  <= 1'b0;
        end else if (clear_i) begin
            break_hit_o <= 1'b0;
            overflow_o  <= 1'b0;
        end else begin
            if (push_o && bp_match) break_hit_o <= 1'b1;   // Matching record is still stored
            if (overrun)            overflow_o  <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: sd_debug_apb_regs.sv
// APB slave of the debug unit with control and break registers, status and buffer drain
`default_nettype none

`include "sd_debug_cfg.svh"

module sd_debug_apb_regs
    import sd_debug_bus_pkg::*;
    import sd_debug_trace_pkg::*;
(
    input  wire                                         PCLK_i,
    input  wire                                         PRESETn_i,
    input  wire apb_req_t                               apb_req_i,
    output apb_rsp_t                                    apb_rsp_o,
    output dbg_ctrl_t                                   ctrl_o,
    output break_cfg_t                                  break_cfg_o,
    output logic                                        clear_o,
    input  wire trace_rec_t                             trace_head_i,
    input  wire [$clog2(`SD_DBG_TRACE_DEPTH+1)-1:0]     trace_level_i,
    input  wire                                         trace_full_i,
    input  wire                                         trace_empty_i,
    output logic                                        trace_pop_o,
    input  wire perf_sample_t                           perf_head_i,
    input  wire                                         perf_full_i,
    input  wire                                         perf_empty_i,
    output logic                                        perf_pop_o,
    input  wire                                         perf_valid_i,
    output logic                                        perf_ready_o,
    output logic                                        perf_push_o,
    input  wire                                         break_hit_i,
    input  wire                                         overflow_i
);

    localparam int LVL_W = $clog2(`SD_DBG_TRACE_DEPTH + 1);
    localparam int IDX_W = $clog2(`SD_DBG_NUM_BREAK);

    dbg_ctrl_t        ctrl_q;
    break_cfg_t       brk_q;
    logic             acc;
    logic             wr;
    logic             rd;
    reg_addr_t        brk_off;
    logic             brk_sel;
    logic [IDX_W-1:0] brk_idx;
    logic             mapped;
    logic             rd_trace;
    logic             rd_perf;
    logic             slv_err;
    logic [31:0]      status;
    logic [31:0]      rdata;

    // ========================================
    // Decode
    // ========================================
    assign acc = apb_req_i.psel & apb_req_i.penable;   // Access phase
    assign wr  = acc & apb_req_i.pwrite;
    assign rd  = acc & ~apb_req_i.pwrite;

    // Break value window, below the base wraps to a large offset
    assign brk_off = apb_req_i.paddr - `SD_DBG_REG_BREAK_VAL;
    assign brk_sel = (brk_off < reg_addr_t'(4 * `SD_DBG_NUM_BREAK)) && (brk_off[1:0] == 2'b00);
    assign brk_idx = brk_off[IDX_W+1:2];

    assign rd_trace    = rd && (apb_req_i.paddr == `SD_DBG_REG_TRACE_DATA);
    assign rd_perf     = rd && (apb_req_i.paddr == `SD_DBG_REG_PERF_DATA);
    assign trace_pop_o = rd_trace & ~trace_empty_i;
    assign perf_pop_o  = rd_perf & ~perf_empty_i;
    assign clear_o     = wr && (apb_req_i.paddr == `SD_DBG_REG_CTRL) && apb_req_i.pwdata[3];

    always_comb begin
        status                = '0;
        status[LVL_W-1:0]     = trace_level_i;
        status[8]             = trace_empty_i;
        status[9]             = trace_full_i;
        status[10]            = perf_empty_i;
        status[11]            = perf_full_i;
        status[12]            = break_hit_i;
        status[13]            = overflow_i;
    end

    // Read-back mux
    always_comb begin
        mapped = 1'b1;
        case (apb_req_i.paddr)
            `SD_DBG_REG_CTRL:       rdata = 32'(ctrl_q);
            `SD_DBG_REG_STATUS:     rdata = status;
            `SD_DBG_REG_TRACE_DATA: rdata = trace_head_i.data;
            `SD_DBG_REG_TRACE_TYPE: rdata = 32'(trace_head_i.rec_type);
            `SD_DBG_REG_BREAK_EN:   rdata = 32'(brk_q.en);
            `SD_DBG_REG_PERF_DATA:  rdata = 32'(perf_head_i);
            default: begin
                mapped = brk_sel;
                rdata  = 32'(brk_q.val[brk_idx]);
            end
        endcase
    end

    // Unmapped offset or popping an empty buffer
    assign slv_err = acc & (~mapped | (rd_trace & trace_empty_i) | (rd_perf & perf_empty_i));

    assign apb_rsp_o = '{
        prdata:  (rd && !slv_err) ? rdata : 32'h0,
        pready:  1'b1,
        pslverr: slv_err
    };

    // ========================================
    // Registers
    // ========================================
    always_ff @(posedge PCLK_i or negedge PRESETn_i) begin
        if (!PRESETn_i) begin
            ctrl_q <= '0;
            brk_q  <= '0;
        end else if (wr) begin
            if (apb_req_i.paddr == `SD_DBG_REG_CTRL) begin
                ctrl_q <= dbg_ctrl_t'(apb_req_i.pwdata[2:0]);   // Bit 3 is the clear strobe
            end
            if (apb_req_i.paddr == `SD_DBG_REG_BREAK_EN) begin
                brk_q.en <= apb_req_i.pwdata[`SD_DBG_NUM_BREAK-1:0];
            end
            if (brk_sel) begin
                brk_q.val[brk_idx] <= apb_req_i.pwdata[15:0];
            end
        end
    end

    assign ctrl_o      = ctrl_q;
    assign break_cfg_o = brk_q;

    // Perf samples need no break or overflow logic
    assign perf_ready_o = ctrl_q.debug_en & ctrl_q.perf_en & ~perf_full_i;
    assign perf_push_o  = perf_valid_i & perf_ready_o;

endmodule

`default_nettype wire

// File: sd_debug_top.sv
// Debug trace unit top level for the SD controller, connects registers, gate and buffers
`default_nettype none

`include "sd_debug_cfg.svh"

module sd_debug_top
    import sd_debug_bus_pkg::*;
    import sd_debug_trace_pkg::*;
(
    input  wire                PCLK_i,
    input  wire                PRESETn_i,
    input  wire apb_req_t      apb_req_i,
    output apb_rsp_t           apb_rsp_o,
    input  wire trace_rec_t    trace_rec_i,
    input  wire                trace_valid_i,
    output logic               trace_ready_o,
    input  wire perf_sample_t  perf_sample_i,
    input  wire                perf_valid_i,
    output logic               perf_ready_o,
    output logic               break_hit_o,
    output logic               debug_error_o
);

    dbg_ctrl_t    ctrl;
    break_cfg_t   break_cfg;
    logic         clear;
    trace_rec_t   trace_head;
    logic [$clog2(`SD_DBG_TRACE_DEPTH+1)-1:0] trace_level;
    logic         trace_full;
    logic         trace_empty;
    logic         trace_push;
    logic         trace_pop;
    perf_sample_t perf_head;
    logic         perf_full;
    logic         perf_empty;
    logic         perf_push;
    logic         perf_pop;

    sd_debug_apb_regs u_regs (
        .PCLK_i        (PCLK_i),
        .PRESETn_i     (PRESETn_i),
        .apb_req_i     (apb_req_i),
        .apb_rsp_o     (apb_rsp_o),
        .ctrl_o        (ctrl),
        .break_cfg_o   (break_cfg),
        .clear_o       (clear),
        .trace_head_i  (trace_head),
        .trace_level_i (trace_level),
        .trace_full_i  (trace_full),
        .trace_empty_i (trace_empty),
        .trace_pop_o   (trace_pop),
        .perf_head_i   (perf_head),
        .perf_full_i   (perf_full),
        .perf_empty_i  (perf_empty),
        .perf_pop_o    (perf_pop),
        .perf_valid_i  (perf_valid_i),
        .perf_ready_o  (perf_ready_o),
        .perf_push_o   (perf_push),
        .break_hit_i   (break_hit_o),
        .overflow_i    (debug_error_o)
    );

    sd_debug_trace_gate u_gate (
        .PCLK_i        (PCLK_i),
        .PRESETn_i     (PRESETn_i),
        .ctrl_i        (ctrl),
        .break_cfg_i   (break_cfg),
        .clear_i       (clear),
        .trace_valid_i (trace_valid_i),
        .trace_rec_i   (trace_rec_i),
        .fifo_full_i   (trace_full),
        .trace_ready_o (trace_ready_o),
        .push_o        (trace_push),
        .break_hit_o   (break_hit_o),
        .overflow_o    (debug_error_o)   // Overflow is the only error source
    );

    // ========================================
    // Buffers
    // ========================================
    sd_debug_fifo #(
        .payload_t (trace_rec_t),
        .DEPTH     (`SD_DBG_TRACE_DEPTH)
    ) u_trace_fifo (
        .PCLK_i    (PCLK_i),
        .PRESETn_i (PRESETn_i),
        .clear_i   (clear),
        .push_i    (trace_push),
        .pop_i     (trace_pop),
        .wdata_i   (trace_rec_i),
        .rdata_o   (trace_head),
        .level_o   (trace_level),
        .full_o    (trace_full),
        .empty_o   (trace_empty)
    );

    // Perf level not reported in STATUS
    sd_debug_fifo #(
        .payload_t (perf_sample_t),
        .DEPTH     (`SD_DBG_PERF_DEPTH)
    ) u_perf_fifo (
        .PCLK_i    (PCLK_i),
        .PRESETn_i (PRESETn_i),
        .clear_i   (clear),
        .push_i    (perf_push),
        .pop_i     (perf_pop),
        .wdata_i   (perf_sample_i),
        .rdata_o   (perf_head),
        .level_o   (),
        .full_o    (perf_full),
        .empty_o   (perf_empty)
    );

endmodule

`default_nettype wire

// File: tb_sd_debug_clk.sv
// Clock and reset source for the debug unit testbench, instantiated once by the testbench top
`default_nettype none

module tb_sd_debug_clk #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 3
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // Reset low from time zero, released on a rising edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

`default_nettype wire

// File: tb_sd_debug.sv
// Directed testbench of the debug trace unit; drives APB, trace and perf ports and checks results
`default_nettype none

`include "sd_debug_cfg.svh"

module tb_sd_debug
    import sd_debug_bus_pkg::*;
    import sd_debug_trace_pkg::*;
();

    localparam int CLK_PERIOD    = 100;
    localparam int TRACE_DEPTH   = `SD_DBG_TRACE_DEPTH;
    localparam int PERF_DEPTH    = `SD_DBG_PERF_DEPTH;
    localparam int TEST_CYCLES   = 10 + 60 + 60 + 45 + 60 + 90;   // Per test, in run order
    localparam int MARGIN_CYCLES = 100;
    localparam logic [15:0] BREAK_VAL = 16'h5D0C;

    logic         clk;
    logic         rst_n;
    apb_req_t     apb_req;
    apb_rsp_t     apb_rsp;
    trace_rec_t   trace_rec;
    logic         trace_valid;
    logic         trace_ready;
    perf_sample_t perf_sample;
    logic         perf_valid;
    logic         perf_ready;
    logic         break_hit;
    logic         debug_error;
    logic [31:0]  lfsr;
    int           errors;
    int           checks;

    tb_sd_debug_clk #(
        .PERIOD       (CLK_PERIOD),
        .RESET_CYCLES (3)
    ) u_clk (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    sd_debug_top u_sd_debug_top (
        .PCLK_i        (clk),
        .PRESETn_i     (rst_n),
        .apb_req_i     (apb_req),
        .apb_rsp_o     (apb_rsp),
        .trace_rec_i   (trace_rec),
        .trace_valid_i (trace_valid),
        .trace_ready_o (trace_ready),
        .perf_sample_i (perf_sample),
        .perf_valid_i  (perf_valid),
        .perf_ready_o  (perf_ready),
        .break_hit_o   (break_hit),
        .debug_error_o (debug_error)
    );

    // ========================================
    // Helpers
    // ========================================

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    // STATUS word as the register map defines it
    function automatic logic [31:0] exp_status(input int level, input bit p_empty,
                                               input bit p_full, input bit hit, input bit ovf);
        logic [31:0] s;
        s       = '0;
        s[4:0]  = 5'(level);
        s[8]    = (level == 0);
        s[9]    = (level == TRACE_DEPTH);
        s[10]   = p_empty;
        s[11]   = p_full;
        s[12]   = hit;
        s[13]   = ovf;
        return s;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error: %s expected %08h actual %08h", name, expected, actual);
        end
    endtask

    task automatic apb_write(input reg_addr_t addr, input logic [31:0] data);
        @(posedge clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(posedge clk);             // Write lands on this edge
        apb_req <= '0;
    endtask

    task automatic apb_read(input reg_addr_t addr, output logic [31:0] data, output logic err);
        @(posedge clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 32'h0};
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);             // Mid access cycle
        data = apb_rsp.prdata;
        err  = apb_rsp.pslverr;
        check_value("apb pready", 1, apb_rsp.pready);
        @(posedge clk);
        apb_req <= '0;
    endtask

    // Holds valid until ready is seen or max_wait cycles pass
    task automatic push_trace(input trace_rec_t rec, input int max_wait, output bit taken);
        int n;
        taken = 1'b0;
        n     = 0;
        @(posedge clk);
        trace_rec   <= rec;
        trace_valid <= 1'b1;
        while (!taken && n < max_wait) begin
            @(negedge clk);
            taken = trace_ready;
            @(posedge clk);
            n++;
        end
        trace_valid <= 1'b0;
    endtask

    task automatic push_perf(input perf_sample_t sample, input int max_wait, output bit taken);
        int n;
        taken = 1'b0;
        n     = 0;
        @(posedge clk);
        perf_sample <= sample;
        perf_valid  <= 1'b1;
        while (!taken && n < max_wait) begin
            @(negedge clk);
            taken = perf_ready;
            @(posedge clk);
            n++;
        end
        perf_valid <= 1'b0;
    endtask

    function automatic trace_rec_t random_rec();
        trace_rec_t rec;
        rec.data     = lfsr_bits(32);
        rec.rec_type = 4'(lfsr_bits(4));
        if (rec.data[15:0] == BREAK_VAL) begin
            rec.data[0] = ~rec.data[0];   // Keep clear of the break value
        end
        return rec;
    endfunction

    // ========================================
    // Directed tests
    // ========================================
    task automatic after_reset();
        logic [31:0] rdata;
        logic        err;
        @(negedge clk);
        check_value("reset trace_ready", 0, trace_ready);
        check_value("reset perf_ready", 0, perf_ready);
        check_value("reset break_hit", 0, break_hit);
        check_value("reset debug_error", 0, debug_error);
        apb_read(`SD_DBG_REG_STATUS, rdata, err);
        check_value("reset status", exp_status(0, 1, 0, 0, 0), rdata);
        check_value("reset status pslverr", 0, err);
    endtask

    task automatic capture_order();
        trace_rec_t  sent [5];
        logic [31:0] rdata;
        logic        err;
        bit          taken;
        apb_write(`SD_DBG_REG_CTRL, 32'h3);   // debug_en and trace_en
        for (int i = 0; i < 5; i++) begin
            sent[i] = random_rec();
            push_trace(sent[i], 8, taken);
            check_value("capture push accepted", 1, taken);
        end
        for (int i = 0; i < 5; i++) begin
            apb_read(`SD_DBG_REG_TRACE_TYPE, rdata, err);
            check_value("capture type", 32'(sent[i].rec_type), rdata);
            apb_read(`SD_DBG_REG_TRACE_DATA, rdata, err);
            check_value("capture data", sent[i].data, rdata);
        end
        apb_read(`SD_DBG_REG_STATUS, rdata, err);
        check_value("capture status", exp_status(0, 1, 0, 0, 0), rdata);
        apb_read(`SD_DBG_REG_TRACE_DATA, rdata, err);
        check_value("empty pop pslverr", 1, err);
        check_value("empty pop data", 0, rdata);
    endtask

    task automatic overflow_and_clear();
        logic [31:0] rdata;
        logic        err;
        bit          taken;
        int          accepted;
        accepted = 0;
        taken    = 1'b1;
        // Last attempt holds valid against a full buffer
        while (taken && accepted <= TRACE_DEPTH) begin
            push_trace(random_rec(), 2, taken);
            if (taken) begin
                accepted++;
            end
        end
        check_value("records accepted", TRACE_DEPTH, accepted);
        @(negedge clk);
        check_value("ready when full", 0, trace_ready);
        check_value("overflow error", 1, debug_error);
        apb_read(`SD_DBG_REG_STATUS, rdata, err);
        check_value("overflow status", exp_status(TRACE_DEPTH, 1, 0, 0, 1), rdata);
        apb_write(`SD_DBG_REG_CTRL, 32'hB);   // Clear, enables kept
        apb_read(`SD_DBG_REG_STATUS, rdata, err);
        check_value("status after clear", exp_status(0, 1, 0, 0, 0), rdata);
        @(negedge clk);
        check_value("error after clear", 0, debug_error);
        check_value("ready after clear", 1, trace_ready);
    endtask

    task automatic break_point_stop();
        trace_rec_t  rec;
        logic [31:0] rdata;
        logic        err;
        bit          taken;
        apb_write(`SD_DBG_REG_BREAK_VAL + 8'h0C, {16'h0, BREAK_VAL});   // Break point 3
        apb_write(`SD_DBG_REG_BREAK_EN, 32'h08);
        for (int i = 0; i < 4; i++) begin
            rec = random_rec();
            if (i == 3) begin
                rec.data[15:0] = BREAK_VAL;
            end
            push_trace(rec, 4, taken);
            check_value("break push accepted", 1, taken);
        end
        @(negedge clk);
        check_value("break hit", 1, break_hit);
        check_value("ready after hit", 0, trace_ready);
        push_trace(random_rec(), 4, taken);
        check_value("push after hit", 0, taken);
        apb_read(`SD_DBG_REG_STATUS, rdata, err);
        check_value("break status", exp_status(4, 1, 0, 1, 0), rdata);
        apb_write(`SD_DBG_REG_CTRL, 32'hB);
        @(negedge clk);
        check_value("hit after clear", 0, break_hit);
        check_value("ready restored", 1, trace_ready);
        apb_write(`SD_DBG_REG_BREAK_EN, 32'h0);
    endtask

    task automatic perf_capture();
        perf_sample_t sent [PERF_DEPTH];
        logic [31:0]  rdata;
        logic         err;
        bit           taken;
        apb_write(`SD_DBG_REG_CTRL, 32'h5);   // debug_en and perf_en
        for (int i = 0; i < PERF_DEPTH; i++) begin
            sent[i] = 16'(lfsr_bits(16));
            push_perf(sent[i], 4, taken);
            check_value("perf push accepted", 1, taken);
        end
        @(negedge clk);
        check_value("perf ready when full", 0, perf_ready);
        apb_read(`SD_DBG_REG_STATUS, rdata, err);
        check_value("perf full status", exp_status(0, 0, 1, 0, 0), rdata);
        for (int i = 0; i < PERF_DEPTH; i++) begin
            apb_read(`SD_DBG_REG_PERF_DATA, rdata, err);
            check_value("perf data", 32'(sent[i]), rdata);
        end
        apb_read(`SD_DBG_REG_STATUS, rdata, err);
        check_value("perf drained status", exp_status(0, 1, 0, 0, 0), rdata);
    endtask

    task automatic register_map();
        logic [31:0] vals [`SD_DBG_NUM_BREAK];
        logic [31:0] rdata;
        logic        err;
        for (int i = 0; i < `SD_DBG_NUM_BREAK; i++) begin
            vals[i] = lfsr_bits(32);
            apb_write(reg_addr_t'(`SD_DBG_REG_BREAK_VAL + 4 * i), vals[i]);
        end
        for (int i = 0; i < `SD_DBG_NUM_BREAK; i++) begin
            apb_read(reg_addr_t'(`SD_DBG_REG_BREAK_VAL + 4 * i), rdata, err);
            check_value("break value readback", {16'h0, vals[i][15:0]}, rdata);
        end
        apb_write(`SD_DBG_REG_BREAK_EN, 32'hA5);
        apb_read(`SD_DBG_REG_BREAK_EN, rdata, err);
        check_value("break enable readback", 32'hA5, rdata);
        apb_write(`SD_DBG_REG_BREAK_EN, 32'h0);
        apb_read(8'h18, rdata, err);            // Hole in the map
        check_value("unmapped 0x18 pslverr", 1, err);
        check_value("unmapped 0x18 data", 0, rdata);
        apb_read(8'h40, rdata, err);            // Past the last break point
        check_value("unmapped 0x40 pslverr", 1, err);
        check_value("unmapped 0x40 data", 0, rdata);
        apb_write(`SD_DBG_REG_CTRL, 32'h6);     // Sub-enables on, master off
        apb_read(`SD_DBG_REG_CTRL, rdata, err);
        check_value("ctrl readback", 32'h6, rdata);
        @(posedge clk);
        trace_rec   <= random_rec();
        trace_valid <= 1'b1;
        perf_sample <= 16'(lfsr_bits(16));
        perf_valid  <= 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_value("trace_ready disabled", 0, trace_ready);
            check_value("perf_ready disabled", 0, perf_ready);
        end
        @(posedge clk);
        trace_valid <= 1'b0;
        perf_valid  <= 1'b0;
        apb_read(`SD_DBG_REG_STATUS, rdata, err);
        check_value("disabled status", exp_status(0, 1, 0, 0, 0), rdata);
    endtask

    // ========================================
    // Run
    // ========================================
    initial begin
        lfsr        = 32'h57da;
        errors      = 0;
        checks      = 0;
        apb_req     = '0;
        trace_rec   = '0;
        trace_valid = 1'b0;
        perf_sample = '0;
        perf_valid  = 1'b0;
        wait (rst_n === 1'b1);
        after_reset();
        capture_order();
        overflow_and_clear();
        break_point_stop();
        perf_capture();
        register_map();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(CLK_PERIOD * (TEST_CYCLES + MARGIN_CYCLES));
        $display("Timeout: the tests did not finish within %0d cycles",
                 TEST_CYCLES + MARGIN_CYCLES);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sd_debug_top.f
+incdir+.
sd_debug_bus_pkg.sv
sd_debug_trace_pkg.sv
sd_debug_fifo.sv
sd_debug_trace_gate.sv
sd_debug_apb_regs.sv
sd_debug_top.sv
tb_sd_debug_clk.sv
tb_sd_debug.sv

// File: run_sim.sh
#!/bin/sh
# Build the debug unit testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_sd_debug \
    -f sd_debug_top.f -o sim_tb_sd_debug
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb_sd_debug > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "test failed" "$LOG"; then
    exit 1
fi

exit 0
